// ==== Bender.yml ====
package:
  name: apb_spi

sources:
  - files:
      - design/spi_reg_pkg.sv
      - design/spi_bus_pkg.sv
      - design/spi_ctrl_if.sv
      - design/apb_slave_interface.sv
      - design/spi_baud_gen.sv
      - design/spi_shift_engine.sv
      - design/apb_spi_top.sv
  - target: test
    files:
      - verif/apb_spi_tb.sv

// ==== all.f ====
design/spi_reg_pkg.sv
design/spi_bus_pkg.sv
design/spi_ctrl_if.sv
design/apb_slave_interface.sv
design/spi_baud_gen.sv
design/spi_shift_engine.sv
design/apb_spi_top.sv
verif/apb_spi_tb.sv

// ==== design/apb_slave_interface.sv ====
`default_nettype none

module apb_slave_interface (
  input  logic                  PClk,
  input  logic                  PRESETn,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  spi_reg_pkg::reg_addr_t paddr,
  input  spi_reg_pkg::spi_byte_t pwdata,
  output spi_reg_pkg::spi_byte_t prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  ss_in,
  output logic                  spi_interrupt_request,
  spi_ctrl_if.regs              ctrl
);
  import spi_reg_pkg::*;
  import spi_bus_pkg::*;

  // State holds the APB phase of the previous cycle.
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ENABLE
  } apb_state_t;

  apb_state_t state;
  apb_state_t next_state;
  spi_mode_t  spi_mode;
  spi_mode_t  next_mode;

  spi_byte_t cr1;
  spi_byte_t cr2;
  spi_byte_t br;
  spi_byte_t dr;
  spi_byte_t sr;
  spi_byte_t rd_mux;

  logic access;
  logic wr_enb;
  logic rd_enb;
  logic dr_wr;
  logic dr_rd;
  logic send_q;
  logic spif;
  logic sptef;
  logic modf;

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = IDLE;
    case (state)
      IDLE: begin
        if (psel && !penable) next_state = SETUP;
      end
      SETUP: begin
        if (psel && penable) next_state = ENABLE;
        else if (psel) next_state = SETUP;
      end
      ENABLE: begin
        if (psel && !penable) next_state = SETUP;
      end
      default: next_state = IDLE;
    endcase
  end

  // Access phase follows a setup phase.
  assign access  = (state == SETUP) && psel && penable;
  assign pready  = access;
  assign pslverr = access && ctrl.tip;
  assign wr_enb  = access && pwrite;
  assign rd_enb  = access && !pwrite;
  assign dr_wr   = wr_enb && (paddr == ADDR_DR) && !ctrl.tip;
  assign dr_rd   = rd_enb && (paddr == ADDR_DR);

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      cr1 <= CR1_RESET;
      cr2 <= CR2_RESET;
      br  <= BR_RESET;
    end else if (wr_enb) begin
      case (paddr)
        ADDR_CR1: cr1 <= pwdata;
        ADDR_CR2: cr2 <= pwdata & CR2_MASK;
        ADDR_BR:  br  <= pwdata & BR_MASK;
        default:  cr1 <= cr1;
      endcase
    end
  end

  // A new byte from the bus takes priority over a received one.
  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      dr <= '0;
    end else if (dr_wr) begin
      dr <= pwdata;
    end else if (ctrl.receive_data) begin
      dr <= ctrl.miso_data;
    end
  end

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      send_q <= 1'b0;
      spif   <= 1'b0;
    end else begin
      send_q <= dr_wr && cr1[CR1_SPE] && cr1[CR1_MSTR] && (spi_mode == SPI_RUN);
      if (ctrl.receive_data) begin
        spif <= 1'b1;
      end else if (dr_rd) begin
        spif <= 1'b0;
      end
    end
  end

  assign sptef = !(send_q || ctrl.tip);
  assign modf  = !ss_in && cr1[CR1_MSTR] && cr2[CR2_MODFEN] && !cr1[CR1_SSOE];

  always_comb begin
    sr           = '0;
    sr[SR_SPIF]  = spif;
    sr[SR_SPTEF] = sptef;
    sr[SR_MODF]  = modf;
  end

  always_comb begin
    case (paddr)
      ADDR_CR1: rd_mux = cr1;
      ADDR_CR2: rd_mux = cr2;
      ADDR_BR:  rd_mux = br;
      ADDR_SR:  rd_mux = sr;
      ADDR_DR:  rd_mux = dr;
      default:  rd_mux = '0;
    endcase
  end

  assign prdata = rd_enb ? rd_mux : '0;

  assign spi_interrupt_request = (cr1[CR1_SPIE] && (spif || modf)) ||
                                 (cr1[CR1_SPTIE] && sptef);

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      spi_mode <= SPI_RUN;
    end else begin
      spi_mode <= next_mode;
    end
  end

  always_comb begin
    next_mode = spi_mode;
    case (spi_mode)
      SPI_RUN: begin
        if (!cr1[CR1_SPE]) next_mode = SPI_WAIT;
      end
      SPI_WAIT: begin
        if (cr1[CR1_SPE]) next_mode = SPI_RUN;
        else if (cr2[CR2_SPISWAI]) next_mode = SPI_STOP;
      end
      SPI_STOP: begin
        if (cr1[CR1_SPE]) next_mode = SPI_RUN;
        else if (!cr2[CR2_SPISWAI]) next_mode = SPI_WAIT;
      end
      default: next_mode = SPI_RUN;
    endcase
  end

  assign ctrl.mstr      = cr1[CR1_MSTR];
  assign ctrl.cpol      = cr1[CR1_CPOL];
  assign ctrl.cpha      = cr1[CR1_CPHA];
  assign ctrl.lsbfe     = cr1[CR1_LSBFE];
  assign ctrl.ssoe      = cr1[CR1_SSOE];
  assign ctrl.sppr      = br[6:4];
  assign ctrl.spr       = br[2:0];
  assign ctrl.spi_mode  = spi_mode;
  assign ctrl.send_data = send_q;
  assign ctrl.mosi_data = dr;

endmodule

`default_nettype wire

// ==== design/apb_spi_top.sv ====
`default_nettype none

module apb_spi_top #(
  parameter int BAUD_CNT_W = 12
) (
  input  logic                  PClk,
  input  logic                  PRESETn,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  spi_reg_pkg::reg_addr_t paddr,
  input  spi_reg_pkg::spi_byte_t pwdata,
  output spi_reg_pkg::spi_byte_t prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  sclk,
  output logic                  mosi,
  input  logic                  miso,
  output logic                  ss,
  output logic                  spi_interrupt_request
);

  spi_ctrl_if ctrl_bus ();

  // Own slave select feeds the mode fault check.
  apb_slave_interface u_regs (
    .PClk                 (PClk),
    .PRESETn              (PRESETn),
    .psel                 (psel),
    .penable              (penable),
    .pwrite               (pwrite),
    .paddr                (paddr),
    .pwdata               (pwdata),
    .prdata               (prdata),
    .pready               (pready),
    .pslverr              (pslverr),
    .ss_in                (ss),
    .spi_interrupt_request(spi_interrupt_request),
    .ctrl                 (ctrl_bus.regs)
  );

  spi_shift_engine #(
    .BAUD_CNT_W(BAUD_CNT_W)
  ) u_engine (
    .PClk   (PClk),
    .PRESETn(PRESETn),
    .ctrl   (ctrl_bus.engine),
    .sclk   (sclk),
    .mosi   (mosi),
    .ss     (ss),
    .miso   (miso)
  );

endmodule

`default_nettype wire

// ==== design/spi_baud_gen.sv ====
`default_nettype none

module spi_baud_gen #(
  parameter int BAUD_CNT_W = 12
) (
  input  logic                  PClk,
  input  logic                  PRESETn,
  input  logic                  run,
  input  logic                  freeze,
  input  logic                  cpol,
  input  spi_reg_pkg::prescale_t sppr,
  input  spi_reg_pkg::prescale_t spr,
  output logic                  sclk,
  output logic                  lead_edge,
  output logic                  trail_edge
);

  logic [BAUD_CNT_W-1:0] cnt;
  logic [BAUD_CNT_W-1:0] half;
  logic                  hit;

  // Half period of (sppr+1) * 2^spr cycles.
  assign half = (BAUD_CNT_W'(sppr) + 1'b1) << spr;
  assign hit  = (cnt == half - 1'b1);

  always_ff @(posedge PClk) begin
    if (!PRESETn || !run) begin
      cnt        <= '0;
      sclk       <= cpol;
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
    end else if (freeze) begin
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
    end else if (hit) begin
      cnt  <= '0;
      sclk <= ~sclk;
      // Leaving the idle level is the leading edge.
      lead_edge  <= (sclk == cpol);
      trail_edge <= (sclk != cpol);
    end else begin
      cnt        <= cnt + 1'b1;
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/spi_bus_pkg.sv ====
`default_nettype none

package spi_bus_pkg;

  // Low power modes of the controller.
  typedef enum logic [1:0] {
    SPI_RUN  = 2'b00,
    SPI_WAIT = 2'b01,
    SPI_STOP = 2'b10
  } spi_mode_t;

  // Counts completed bits of a byte.
  typedef logic [2:0] bit_cnt_t;

endpackage

`default_nettype wire

// ==== design/spi_ctrl_if.sv ====
`default_nettype none

interface spi_ctrl_if;
  import spi_reg_pkg::*;
  import spi_bus_pkg::*;

  // Configuration from the register block.
  logic      mstr;
  logic      cpol;
  logic      cpha;
  logic      lsbfe;
  logic      ssoe;
  prescale_t sppr;
  prescale_t spr;
  spi_mode_t spi_mode;

  // Transfer strobes and data.
  logic      send_data;
  spi_byte_t mosi_data;
  logic      tip;
  logic      receive_data;
  spi_byte_t miso_data;

  modport regs (
    output mstr, cpol, cpha, lsbfe, ssoe, sppr, spr, spi_mode, send_data, mosi_data,
    input  tip, receive_data, miso_data
  );

  modport engine (
    input  mstr, cpol, cpha, lsbfe, ssoe, sppr, spr, spi_mode, send_data, mosi_data,
    output tip, receive_data, miso_data
  );

endinterface

`default_nettype wire

// ==== design/spi_reg_pkg.sv ====
`default_nettype none

package spi_reg_pkg;

  typedef logic [2:0] reg_addr_t;
  typedef logic [7:0] spi_byte_t;
  typedef logic [2:0] prescale_t;

  // Register offsets.
  localparam reg_addr_t ADDR_CR1 = 3'd0;
  localparam reg_addr_t ADDR_CR2 = 3'd1;
  localparam reg_addr_t ADDR_BR  = 3'd2;
  localparam reg_addr_t ADDR_SR  = 3'd3;
  localparam reg_addr_t ADDR_DR  = 3'd5;

  localparam spi_byte_t CR2_MASK = 8'h1B;
  localparam spi_byte_t BR_MASK  = 8'h77;

  localparam spi_byte_t CR1_RESET = 8'h04;
  localparam spi_byte_t CR2_RESET = 8'h00;
  localparam spi_byte_t BR_RESET  = 8'h00;

  // CR1 fields.
  localparam int CR1_SPIE  = 7;
  localparam int CR1_SPE   = 6;
  localparam int CR1_SPTIE = 5;
  localparam int CR1_MSTR  = 4;
  localparam int CR1_CPOL  = 3;
  localparam int CR1_CPHA  = 2;
  localparam int CR1_SSOE  = 1;
  localparam int CR1_LSBFE = 0;

  localparam int CR2_MODFEN  = 4;
  localparam int CR2_SPISWAI = 1;

  // Status flags.
  localparam int SR_SPIF  = 7;
  localparam int SR_SPTEF = 5;
  localparam int SR_MODF  = 4;

endpackage

`default_nettype wire

// ==== design/spi_shift_engine.sv ====
`default_nettype none

module spi_shift_engine #(
  parameter int BAUD_CNT_W = 12
) (
  input  logic       PClk,
  input  logic       PRESETn,
  spi_ctrl_if.engine ctrl,
  output logic       sclk,
  output logic       mosi,
  output logic       ss,
  input  logic       miso
);
  import spi_reg_pkg::*;
  import spi_bus_pkg::*;

  spi_byte_t tx_q;
  spi_byte_t rx_q;
  bit_cnt_t  bit_cnt;

  logic tip_q;
  logic rx_done;
  logic start;
  logic lead_edge;
  logic trail_edge;
  logic last_trail;
  logic sample;
  logic shift;
  logic baud_run;
  logic baud_freeze;

  assign start      = ctrl.send_data && !tip_q && ctrl.mstr;
  assign last_trail = trail_edge && (bit_cnt == bit_cnt_t'(7));

  // Stop the divider on the last edge so sclk rests at cpol.
  assign baud_run    = tip_q && !last_trail;
  assign baud_freeze = (ctrl.spi_mode == SPI_STOP);

  spi_baud_gen #(
    .BAUD_CNT_W(BAUD_CNT_W)
  ) u_baud_gen (
    .PClk      (PClk),
    .PRESETn   (PRESETn),
    .run       (baud_run),
    .freeze    (baud_freeze),
    .cpol      (ctrl.cpol),
    .sppr      (ctrl.sppr),
    .spr       (ctrl.spr),
    .sclk      (sclk),
    .lead_edge (lead_edge),
    .trail_edge(trail_edge)
  );

  // With cpha set the first lead edge finds the first bit already out.
  assign sample = ctrl.cpha ? trail_edge : lead_edge;
  assign shift  = ctrl.cpha ? (lead_edge && (bit_cnt != '0)) : trail_edge;

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      tip_q   <= 1'b0;
      rx_done <= 1'b0;
      ss      <= 1'b1;
      bit_cnt <= '0;
    end else begin
      rx_done <= last_trail;
      if (start) begin
        tip_q   <= 1'b1;
        ss      <= !ctrl.ssoe;
        bit_cnt <= '0;
      end else if (last_trail) begin
        tip_q <= 1'b0;
        ss    <= 1'b1;
      end else if (trail_edge) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge PClk) begin
    if (!PRESETn) begin
      tx_q <= '0;
      rx_q <= '0;
    end else begin
      if (start) begin
        tx_q <= ctrl.mosi_data;
      end else if (shift) begin
        tx_q <= ctrl.lsbfe ? {1'b0, tx_q[7:1]} : {tx_q[6:0], 1'b0};
      end
      if (sample) begin
        rx_q <= ctrl.lsbfe ? {miso, rx_q[7:1]} : {rx_q[6:0], miso};
      end
    end
  end

  assign mosi = ctrl.lsbfe ? tx_q[0] : tx_q[7];

  assign ctrl.tip          = tip_q;
  assign ctrl.receive_data = rx_done;
  assign ctrl.miso_data    = rx_q;

endmodule

`default_nettype wire

// ==== verif/apb_spi_stimulus.txt ====
// op addr data expect; op 0 write (expect pslverr), 1 read, 2 transfer (expect half period)
// op 3 DR readback, 4 interrupt level, 5 transfer with busy DR write, 6 transfer with stop pause
1 0 00 04
1 1 00 00
1 2 00 00
0 0 FF 00
1 0 00 FF
0 1 FF 00
1 1 00 1B
0 2 FF 00
1 2 00 77
0 1 00 00
0 2 00 00
0 0 52 00
2 0 00 01
1 3 00 A0
3 5 00 00
1 3 00 20
0 2 11 00
0 0 5E 00
2 0 00 04
3 5 00 00
0 2 12 00
0 0 57 00
2 0 00 08
3 5 00 00
0 2 20 00
0 0 59 00
2 0 00 03
3 5 00 00
0 0 D2 00
5 5 3C 03
4 0 00 01
3 5 00 00
4 0 00 00
0 2 13 00
6 0 02 40
3 5 00 00

// ==== verif/apb_spi_tb.sv ====
`default_nettype none

module apb_spi_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import spi_reg_pkg::*;

  localparam int MAX_REC = 64;

  logic      PClk = 1'b0;
  logic      PRESETn;
  logic      psel;
  logic      penable;
  logic      pwrite;
  reg_addr_t paddr;
  spi_byte_t pwdata;
  spi_byte_t prdata;
  logic      pready;
  logic      pslverr;
  logic      sclk;
  logic      mosi;
  logic      ss;
  logic      spi_interrupt_request;

  // Each record is four words of op, address, data and expected value.
  logic [7:0] stim [0:4*MAX_REC-1];
  int         n_rec = 0;
  int         toggle_cnt;
  spi_byte_t  cr1_q;
  spi_byte_t  last_payload;

  always #50 PClk = ~PClk;

  // Serial data loops back from mosi to miso.
  apb_spi_top #(
    .BAUD_CNT_W(12)
  ) apb_spi_top_inst (
    .PClk                 (PClk),
    .PRESETn              (PRESETn),
    .psel                 (psel),
    .penable              (penable),
    .pwrite               (pwrite),
    .paddr                (paddr),
    .pwdata               (pwdata),
    .prdata               (prdata),
    .pready               (pready),
    .pslverr              (pslverr),
    .sclk                 (sclk),
    .mosi                 (mosi),
    .miso                 (mosi),
    .ss                   (ss),
    .spi_interrupt_request(spi_interrupt_request)
  );

  task automatic stop_run;
    begin
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string what);
    begin
      $display("%s", what);
      stop_run();
    end
  endtask

  task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
    if (got !== exp) begin
      $display("error: %s = %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s = %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error: %s = %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic apb_write(input reg_addr_t addr, input spi_byte_t data, input logic exp_err);
    begin
      @(posedge PClk);
      #5;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge PClk);
      #5;
      penable = 1'b1;
      @(negedge PClk);
      check_bit("pready", pready, 1'b1);
      check_bit("pslverr", pslverr, exp_err);
      @(posedge PClk);
      #5;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
    end
  endtask

  task automatic apb_read(input reg_addr_t addr, output spi_byte_t data, output logic err);
    begin
      @(posedge PClk);
      #5;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge PClk);
      #5;
      penable = 1'b1;
      @(negedge PClk);
      check_bit("pready", pready, 1'b1);
      data = prdata;
      err  = pslverr;
      @(posedge PClk);
      #5;
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  // Collects mosi on the sampling edges and times each half period.
  task automatic monitor_byte(input int exp_half, input logic measure, output spi_byte_t got);
    logic prev;
    int   since;
    int   cycles;
    begin
      prev   = sclk;
      since  = 0;
      cycles = 0;
      got    = '0;
      while (toggle_cnt < 16) begin
        @(negedge PClk);
        since++;
        cycles++;
        if (cycles > 5000) report_failure("transfer did not finish in time");
        if (sclk !== prev) begin
          toggle_cnt++;
          if (measure && toggle_cnt > 1) check_count("half period", since, exp_half);
          since = 0;
          prev  = sclk;
          // Leading edge samples when cpha is 0, trailing edge when cpha is 1.
          if ((sclk != cr1_q[CR1_CPOL]) != cr1_q[CR1_CPHA]) begin
            got = cr1_q[CR1_LSBFE] ? {mosi, got[7:1]} : {got[6:0], mosi};
          end
        end
        if (toggle_cnt > 0 && cr1_q[CR1_SSOE]) check_bit("ss", ss, 1'b0);
      end
    end
  endtask

  task automatic busy_write(input spi_byte_t data);
    begin
      wait (toggle_cnt >= 4);
      apb_write(ADDR_DR, data, 1'b1);
    end
  endtask

  // Toggles are counted on falling edges, so the count is read on rising edges.
  task automatic stop_pause(input spi_byte_t cr2_val, input int cycles);
    int snap;
    begin
      wait (toggle_cnt >= 6);
      apb_write(ADDR_CR1, cr1_q & ~(spi_byte_t'(1) << CR1_SPE), 1'b1);
      apb_write(ADDR_CR2, cr2_val, 1'b1);
      repeat (2) @(posedge PClk);
      snap = toggle_cnt;
      repeat (cycles) @(posedge PClk);
      check_count("sclk toggles", toggle_cnt, snap);
      apb_write(ADDR_CR1, cr1_q, 1'b1);
    end
  endtask

  task automatic run_transfer(input int mode, input spi_byte_t alt, input int exp);
    spi_byte_t payload;
    spi_byte_t got;
    spi_byte_t status;
    logic      err;
    int        polls;
    begin
      payload      = spi_byte_t'($urandom);
      last_payload = payload;
      @(posedge PClk);
      @(negedge PClk);
      check_bit("sclk", sclk, cr1_q[CR1_CPOL]);
      apb_write(ADDR_DR, payload, 1'b0);
      toggle_cnt = 0;
      fork
        monitor_byte(exp, mode != 6, got);
        begin
          if (mode == 5) busy_write(alt);
          else if (mode == 6) stop_pause(alt, exp);
        end
      join
      check_byte("mosi byte", got, payload);
      polls  = 0;
      status = '0;
      while (!status[SR_SPIF]) begin
        if (polls == 20) report_failure("spif did not rise after the transfer");
        apb_read(ADDR_SR, status, err);
        check_bit("pslverr", err, 1'b0);
        polls++;
      end
      check_bit("sclk", sclk, cr1_q[CR1_CPOL]);
      check_bit("ss", ss, 1'b1);
    end
  endtask

  initial begin
    wait (PRESETn === 1'b1);
    #(n_rec * 40000);
    report_failure("watchdog expired before the stimulus finished");
  end

  initial begin
    logic [7:0] op;
    logic [7:0] data;
    logic [7:0] exp;
    reg_addr_t  addr;
    spi_byte_t  rdata;
    logic       err;
    void'($urandom(76));
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    PRESETn = 1'b0;
    cr1_q   = CR1_RESET;
    $readmemh("verif/apb_spi_stimulus.txt", stim);
    while (n_rec < MAX_REC && !$isunknown(stim[4*n_rec])) n_rec++;
    if (n_rec == 0) report_failure("stimulus file is empty or missing");
    repeat (8) @(posedge PClk);
    #5;
    PRESETn = 1'b1;
    for (int i = 0; i < n_rec; i++) begin
      op   = stim[4*i];
      addr = reg_addr_t'(stim[4*i+1]);
      data = stim[4*i+2];
      exp  = stim[4*i+3];
      case (op)
        8'd0: begin
          apb_write(addr, data, exp[0]);
          if (addr == ADDR_CR1) cr1_q = data;
        end
        8'd1: begin
          apb_read(addr, rdata, err);
          check_bit("pslverr", err, 1'b0);
          check_byte("prdata", rdata, exp);
        end
        8'd2, 8'd5, 8'd6: run_transfer(op, data, exp);
        8'd3: begin
          apb_read(ADDR_DR, rdata, err);
          check_bit("pslverr", err, 1'b0);
          check_byte("prdata", rdata, last_payload);
        end
        8'd4: begin
          @(negedge PClk);
          check_bit("spi_interrupt_request", spi_interrupt_request, exp[0]);
        end
        default: report_failure("unknown operation in the stimulus file");
      endcase
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
